//--- Makefile
# tool, flags, top module and file list
TOOL      = verilator
TOP       = tb_frame_timing
FILELIST  = project.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LOG       = sim.log
PASS_TEXT = sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF "$(PASS_TEXT)" $(LOG); then \
		echo "test target: pass line found"; \
	else \
		echo "test target: pass line missing"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+verification
src/dvbs2_mode_pkg.sv
src/ts_stream_pkg.sv
src/frame_len_lut.sv
src/frame_sequencer.sv
src/ts_packet_source.sv
src/dvbs2_frame_timing_top.sv
verification/tb_frame_timing.sv

//--- src/dvbs2_frame_timing_top.sv
`timescale 1ns/10ps

module dvbs2_frame_timing_top (
	input  logic                      sys_clk,
	input  logic                      glb_rst_n,
	// symbol rate strobe
	input  logic                      sym_en,
	// ts byte rate strobe
	input  logic                      ts_byte_en,
	input  dvbs2_mode_pkg::mode_cfg_t mode_cfg,
	output logic                      frame_start,
	output logic                      bb_frame_vld,
	output logic                      ts_rd_vld,
	output ts_stream_pkg::ts_beat_t   ts_beat
);

	//////////////////////////////////////////////////////////////////////
	// frame timing path
	//////////////////////////////////////////////////////////////////////

	// registered lengths of the current mode
	dvbs2_mode_pkg::frame_len_t frame_len;

	frame_len_lut u_frame_len_lut (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.mode_cfg  (mode_cfg),
		.frame_len (frame_len)
	);

	frame_sequencer u_frame_sequencer (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.sym_en       (sym_en),
		.frame_len    (frame_len),
		.frame_start  (frame_start),
		.bb_frame_vld (bb_frame_vld),
		.ts_rd_vld    (ts_rd_vld)
	);

	//////////////////////////////////////////////////////////////////////
	// stream source independent of the frame timing
	//////////////////////////////////////////////////////////////////////

	ts_packet_source u_ts_packet_source (
		.sys_clk    (sys_clk),
		.glb_rst_n  (glb_rst_n),
		.ts_byte_en (ts_byte_en),
		.ts_beat    (ts_beat)
	);

endmodule

//--- src/dvbs2_mode_pkg.sv
package dvbs2_mode_pkg;

	//////////////////////////////////////////////////////////////////////
	// mode configuration and frame length types
	//////////////////////////////////////////////////////////////////////

	// one mode word as set by the host
	typedef struct packed {
		// 1 = short frame (16200 bits), 0 = normal
		logic       frame_short;
		// ldpc code rate index
		logic [3:0] ldpc_rate;
		logic       pilot_on;
		// 0 qpsk, 1 8psk, 2 16apsk, 3 32apsk
		logic [1:0] mod_order;
	} mode_cfg_t;

	// lengths derived from one mode word
	typedef struct packed {
		// bch data field in bytes
		logic [12:0] kbch_bytes;
		// transport stream bytes carried per frame
		logic [12:0] ts_bytes;
		// physical layer frame length in symbols
		logic [15:0] pl_len;
	} frame_len_t;

	// position inside the pl frame
	typedef logic [15:0] phase_t;

	//////////////////////////////////////////////////////////////////////
	// length tables
	//////////////////////////////////////////////////////////////////////

	// length held by the sequencer until the first reload
	localparam logic [15:0] pl_len_reset = 16'd9990;

	// bbheader plus crc space taken off kbch for the ts payload
	localparam logic [12:0] ts_overhead_bytes = 13'd10;

	// number of listed rates per frame size
	localparam logic [3:0] kbch_long_rates  = 4'd11;
	localparam logic [3:0] kbch_short_rates = 4'd10;

	// normal frame rates 1/4 up to 9/10
	localparam logic [12:0] kbch_long_table [0:10] = '{
		13'd2001, 13'd2676, 13'd3216, 13'd4026,
		13'd4836, 13'd5380, 13'd6051, 13'd6456,
		13'd6730, 13'd7184, 13'd7274
	};

	// short frame has no 9/10 rate
	localparam logic [12:0] kbch_short_table [0:9] = '{
		13'd384,  13'd654,  13'd789,  13'd879,
		13'd1194, 13'd1329, 13'd1464, 13'd1554,
		13'd1644, 13'd1779
	};

	// index is {frame_short, pilot_on, mod_order}
	localparam logic [15:0] pl_len_table [0:15] = '{
		// normal frame without pilots
		16'd32490, 16'd21690, 16'd16290, 16'd13050,
		// normal frame with pilots
		16'd33282, 16'd22194, 16'd16686, 16'd13338,
		// short frame without pilots
		16'd8190,  16'd5490,  16'd4140,  16'd3330,
		// short frame with pilots
		16'd8370,  16'd5598,  16'd4212,  16'd3402
	};

endpackage

//--- src/frame_len_lut.sv
`timescale 1ns/10ps

module frame_len_lut (
	input  logic                     sys_clk,
	input  logic                     glb_rst_n,
	input  dvbs2_mode_pkg::mode_cfg_t  mode_cfg,
	output dvbs2_mode_pkg::frame_len_t frame_len
);

	//////////////////////////////////////////////////////////////////////
	// kbch selection
	//////////////////////////////////////////////////////////////////////

	// rate is inside the table of the chosen frame size
	logic        rate_listed;
	logic [12:0] kbch_sel;
	logic [12:0] ts_sel;
	// pl table index
	logic [3:0]  pl_idx;
	logic [15:0] pl_sel;

	always_comb begin
		rate_listed = 1'b0;
		kbch_sel    = 13'd0;
		if (mode_cfg.frame_short) begin
			// short frame has ten rates
			if (mode_cfg.ldpc_rate < dvbs2_mode_pkg::kbch_short_rates) begin
				rate_listed = 1'b1;
				kbch_sel    = dvbs2_mode_pkg::kbch_short_table[mode_cfg.ldpc_rate];
			end
		end
		else begin
			// normal frame has eleven
			if (mode_cfg.ldpc_rate < dvbs2_mode_pkg::kbch_long_rates) begin
				rate_listed = 1'b1;
				kbch_sel    = dvbs2_mode_pkg::kbch_long_table[mode_cfg.ldpc_rate];
			end
		end
	end

	// ts payload is kbch less header and crc
	always_comb begin
		if (rate_listed) begin
			ts_sel = kbch_sel - dvbs2_mode_pkg::ts_overhead_bytes;
		end
		else begin
			ts_sel = 13'd0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pl frame length
	//////////////////////////////////////////////////////////////////////

	// all sixteen combinations are listed
	assign pl_idx = {mode_cfg.frame_short, mode_cfg.pilot_on, mode_cfg.mod_order};
	assign pl_sel = dvbs2_mode_pkg::pl_len_table[pl_idx];

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	// lengths follow the mode one clock later
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			frame_len.kbch_bytes <= 13'd0;
			frame_len.ts_bytes   <= 13'd0;
			frame_len.pl_len     <= 16'd0;
		end
		else begin
			// unlisted rates leave both windows closed
			frame_len.kbch_bytes <= kbch_sel;
			frame_len.ts_bytes   <= ts_sel;
			frame_len.pl_len     <= pl_sel;
		end
	end

endmodule

//--- src/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer (
	input  logic                       sys_clk,
	input  logic                       glb_rst_n,
	input  logic                       sym_en,
	input  dvbs2_mode_pkg::frame_len_t frame_len,
	output logic                       frame_start,
	output logic                       bb_frame_vld,
	output logic                       ts_rd_vld
);

	//////////////////////////////////////////////////////////////////////
	// frame phase accumulator
	//////////////////////////////////////////////////////////////////////

	dvbs2_mode_pkg::phase_t phase;
	// phase after this strobe
	dvbs2_mode_pkg::phase_t phase_inc;
	// length of the frame now running
	logic [15:0] pl_len_held;
	// next phase reaches the end of frame
	logic        wrap;

	assign phase_inc = phase + 16'd1;
	assign wrap      = (phase_inc >= pl_len_held);

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			phase       <= 16'd0;
			pl_len_held <= dvbs2_mode_pkg::pl_len_reset;
			frame_start <= 1'b0;
		end
		else begin
			// single clock pulse
			frame_start <= 1'b0;
			if (sym_en) begin
				if (wrap) begin
					// keep the excess so the phase never drifts
					phase       <= phase_inc - pl_len_held;
					// new mode only takes effect at the boundary
					pl_len_held <= frame_len.pl_len;
					frame_start <= 1'b1;
				end
				else begin
					phase <= phase_inc;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// windows
	//////////////////////////////////////////////////////////////////////

	// lengths widened to phase width
	logic [15:0] kbch_end;
	logic [15:0] ts_end;
	logic        phase_nz;

	assign kbch_end = {3'b000, frame_len.kbch_bytes};
	assign ts_end   = {3'b000, frame_len.ts_bytes};
	// phase zero is the gap after wrap
	assign phase_nz = (phase != 16'd0);

	// bbscrambler window covers phase 1..kbch
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			bb_frame_vld <= 1'b0;
		end
		else begin
			bb_frame_vld <= phase_nz && (phase <= kbch_end);
		end
	end

	// ts read window covers phase 1..ts bytes
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			ts_rd_vld <= 1'b0;
		end
		else begin
			ts_rd_vld <= phase_nz && (phase <= ts_end);
		end
	end

endmodule

//--- src/ts_packet_source.sv
`timescale 1ns/10ps

module ts_packet_source (
	input  logic                     sys_clk,
	input  logic                     glb_rst_n,
	input  logic                     ts_byte_en,
	output ts_stream_pkg::ts_beat_t  ts_beat
);

	//////////////////////////////////////////////////////////////////////
	// packet position counter
	//////////////////////////////////////////////////////////////////////

	ts_stream_pkg::ts_pos_t pos;
	logic                   pos_first;
	logic                   pos_last;

	assign pos_first = (pos == 8'd0);
	assign pos_last  = (pos == ts_stream_pkg::ts_packet_bytes - 8'd1);

	// wraps modulo 188 on each byte strobe
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			pos <= 8'd0;
		end
		else if (ts_byte_en) begin
			if (pos_last) begin
				pos <= 8'd0;
			end
			else begin
				pos <= pos + 8'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// beat flags and data
	//////////////////////////////////////////////////////////////////////

	logic       beat_syn;
	logic       beat_head;
	logic [7:0] beat_data;

	// flags follow the strobe by one clock
	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			beat_syn  <= 1'b0;
			beat_head <= 1'b0;
		end
		else begin
			beat_syn  <= ts_byte_en;
			beat_head <= ts_byte_en && pos_first;
		end
	end

	// sync byte opens the packet, rest carry their position
	always_ff @(posedge sys_clk) begin
		if (ts_byte_en) begin
			beat_data <= pos_first ? ts_stream_pkg::ts_sync_byte : pos;
		end
	end

	assign ts_beat.data = beat_data;
	assign ts_beat.syn  = beat_syn;
	assign ts_beat.head = beat_head;

endmodule

//--- src/ts_stream_pkg.sv
package ts_stream_pkg;

	//////////////////////////////////////////////////////////////////////
	// mpeg transport stream constants and beat
	//////////////////////////////////////////////////////////////////////

	// byte position inside one packet
	typedef logic [7:0] ts_pos_t;

	localparam ts_pos_t ts_packet_bytes = 8'd188;

	// first byte of every packet
	localparam logic [7:0] ts_sync_byte = 8'h47;

	// one byte on the stream
	typedef struct packed {
		logic [7:0] data;
		// byte valid
		logic       syn;
		// first byte of packet
		logic       head;
	} ts_beat_t;

endpackage

//--- verification/tb_frame_timing_model.svh
`ifndef tb_frame_timing_model_svh
`define tb_frame_timing_model_svh

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	// one mode word and the lengths it should give
	typedef struct packed {
		logic        frame_short;
		logic [3:0]  ldpc_rate;
		logic        pilot_on;
		logic [1:0]  mod_order;
		logic [12:0] kbch;
		logic [12:0] ts;
		logic [15:0] pl;
	} expect_row_t;

	localparam int row_count = 7;

	// ts is kbch less 10 bytes
	// pl from frame size, pilots and modulation
	// short frame rate 10 is unlisted, so both windows stay shut
	localparam expect_row_t table_rows [0:row_count-1] = '{
		'{1'b0, 4'd3,  1'b0, 2'd0, 13'd4026, 13'd4016, 16'd32490},
		'{1'b0, 4'd10, 1'b1, 2'd3, 13'd7274, 13'd7264, 16'd13338},
		'{1'b1, 4'd0,  1'b0, 2'd1, 13'd384,  13'd374,  16'd5490},
		'{1'b1, 4'd9,  1'b1, 2'd2, 13'd1779, 13'd1769, 16'd4212},
		'{1'b1, 4'd10, 1'b0, 2'd0, 13'd0,    13'd0,    16'd8190},
		'{1'b1, 4'd5,  1'b0, 2'd3, 13'd1329, 13'd1319, 16'd3330},
		'{1'b1, 4'd2,  1'b1, 2'd0, 13'd789,  13'd779,  16'd8370}
	};

	// wait limits in clocks
	localparam int first_limit = 20000;
	localparam int frame_limit = 200000;
	localparam int ts_limit    = 4000;

	//////////////////////////////////////////////////////////////////////
	// compare and wait helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// returns on the clock where frame_start is high
	task automatic wait_frame_start(input int limit, input string during);
		int waited;
		if (timeout_count != 0) begin
			return;
		end
		waited = 0;
		while (frame_start !== 1'b1 && waited < limit) begin
			next_clock();
			waited++;
		end
		if (frame_start !== 1'b1) begin
			timeout_count++;
			$display("frame_start never came within %0d clocks %s", limit, during);
		end
	endtask

	// strobes seen from reset up to the first frame start
	task automatic count_first_frame(output int strobes);
		int waited;
		strobes = 0;
		waited = 0;
		while (frame_start !== 1'b1 && waited < first_limit) begin
			if (sym_en) begin
				strobes++;
			end
			next_clock();
			waited++;
		end
		if (frame_start !== 1'b1) begin
			timeout_count++;
			$display("frame_start never came within %0d clocks after reset", first_limit);
		end
	endtask

`endif

//--- verification/tb_frame_timing.sv
`timescale 1ns/10ps

module tb_frame_timing;

	//////////////////////////////////////////////////////////////////////
	// dut signals and stimulus state
	//////////////////////////////////////////////////////////////////////

	logic                      sys_clk;
	logic                      glb_rst_n;
	logic                      sym_en;
	logic                      ts_byte_en;
	dvbs2_mode_pkg::mode_cfg_t mode_cfg;
	logic                      frame_start;
	logic                      bb_frame_vld;
	logic                      ts_rd_vld;
	ts_stream_pkg::ts_beat_t   ts_beat;

	// mode for the next rising edge
	dvbs2_mode_pkg::mode_cfg_t cfg_next;
	// symbol strobe off, held or random
	logic   sym_on;
	logic   sym_random;
	logic   ts_random;
	integer seed;

	int error_count;
	int timeout_count;
	int first_strobes;

	dvbs2_frame_timing_top UUT (
		.sys_clk      (sys_clk),
		.glb_rst_n    (glb_rst_n),
		.sym_en       (sym_en),
		.ts_byte_en   (ts_byte_en),
		.mode_cfg     (mode_cfg),
		.frame_start  (frame_start),
		.bb_frame_vld (bb_frame_vld),
		.ts_rd_vld    (ts_rd_vld),
		.ts_beat      (ts_beat)
	);

	`include "tb_frame_timing_model.svh"

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// clock step and stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// drive on the rising edge, return at the falling edge
	task automatic next_clock();
		logic [31:0] rnd;
		@(posedge sys_clk);
		rnd = $random(seed);
		if (!sym_on) begin
			sym_en <= 1'b0;
		end
		else if (sym_random) begin
			sym_en <= rnd[0];
		end
		else begin
			sym_en <= 1'b1;
		end
		rnd = $random(seed);
		ts_byte_en <= ts_random & rnd[0];
		mode_cfg   <= cfg_next;
		@(negedge sys_clk);
	endtask

	function automatic dvbs2_mode_pkg::mode_cfg_t cfg_of(input expect_row_t r);
		dvbs2_mode_pkg::mode_cfg_t c;
		c.frame_short = r.frame_short;
		c.ldpc_rate   = r.ldpc_rate;
		c.pilot_on    = r.pilot_on;
		c.mod_order   = r.mod_order;
		return c;
	endfunction

	// entered on a frame_start clock, left on the next one
	task automatic measure_frame(input expect_row_t r, input logic with_windows);
		int   strobes;
		int   bb_cycles;
		int   ts_cycles;
		int   clocks;
		logic closed;
		if (timeout_count != 0) begin
			return;
		end
		strobes   = 0;
		bb_cycles = 0;
		ts_cycles = 0;
		clocks    = 0;
		closed    = 1'b0;
		// strobe visible now is taken at the coming edge
		if (sym_en) begin
			strobes++;
		end
		while (!closed && clocks < frame_limit) begin
			next_clock();
			clocks++;
			// windows lag the phase by one clock
			if (bb_frame_vld) begin
				bb_cycles++;
			end
			if (ts_rd_vld) begin
				ts_cycles++;
			end
			if (frame_start) begin
				closed = 1'b1;
			end
			else if (sym_en) begin
				strobes++;
			end
		end
		if (!closed) begin
			timeout_count++;
			$display("frame did not close within %0d clocks", frame_limit);
		end
		else begin
			check_value("sym_en strobes per frame", strobes, 32'(r.pl));
			if (with_windows) begin
				check_value("bb_frame_vld cycles per frame", bb_cycles, 32'(r.kbch));
				check_value("ts_rd_vld cycles per frame", ts_cycles, 32'(r.ts));
			end
		end
	endtask

	// new mode, skip the frame still on the old length, then measure
	task automatic apply_row(input expect_row_t r);
		if (timeout_count != 0) begin
			return;
		end
		cfg_next   = cfg_of(r);
		sym_random = 1'b0;
		// lookup needs one clock before a wrap can load it
		repeat (3) next_clock();
		wait_frame_start(frame_limit, "after a mode change");
		measure_frame(r, 1'b1);
		sym_random = 1'b1;
		measure_frame(r, 1'b0);
		sym_random = 1'b0;
	endtask

	// random byte strobes against a packet position model
	task automatic check_ts_stream(input int heads_wanted);
		int         waited;
		int         heads_seen;
		logic       prev_en;
		logic       data_known;
		logic [7:0] model_pos;
		logic [7:0] strobe_pos;
		logic [7:0] exp_data;
		if (timeout_count != 0) begin
			return;
		end
		waited     = 0;
		heads_seen = 0;
		prev_en    = ts_byte_en;
		data_known = 1'b0;
		model_pos  = 8'd0;
		strobe_pos = 8'd0;
		exp_data   = 8'd0;
		ts_random  = 1'b1;
		while (heads_seen < heads_wanted && waited < ts_limit) begin
			next_clock();
			waited++;
			check_value("ts_beat.syn", 32'(ts_beat.syn), 32'(prev_en));
			check_value("ts_beat.head", 32'(ts_beat.head), 32'(prev_en && strobe_pos == 8'd0));
			if (prev_en) begin
				// sync byte opens every packet
				exp_data   = (strobe_pos == 8'd0) ? 8'h47 : strobe_pos;
				data_known = 1'b1;
			end
			if (data_known) begin
				check_value("ts_beat.data", 32'(ts_beat.data), 32'(exp_data));
			end
			if (ts_beat.head === 1'b1) begin
				heads_seen++;
			end
			prev_en = ts_byte_en;
			if (ts_byte_en) begin
				strobe_pos = model_pos;
				model_pos  = (model_pos == 8'd187) ? 8'd0 : model_pos + 8'd1;
			end
		end
		ts_random = 1'b0;
		if (heads_seen < heads_wanted) begin
			timeout_count++;
			$display("only %0d packet heads came within %0d clocks", heads_seen, ts_limit);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed          = 32'ha2dc926c;
		error_count   = 0;
		timeout_count = 0;
		sym_on        = 1'b0;
		sym_random    = 1'b0;
		ts_random     = 1'b0;
		cfg_next      = cfg_of(table_rows[0]);
		glb_rst_n  <= 1'b0;
		sym_en     <= 1'b0;
		ts_byte_en <= 1'b0;
		mode_cfg   <= cfg_next;
		repeat (2) @(posedge sys_clk);
		glb_rst_n <= 1'b1;
		@(negedge sys_clk);

		// quiet outputs before any strobe
		check_value("frame_start after reset", 32'(frame_start), 32'd0);
		check_value("bb_frame_vld after reset", 32'(bb_frame_vld), 32'd0);
		check_value("ts_rd_vld after reset", 32'(ts_rd_vld), 32'd0);
		check_value("ts_beat.syn after reset", 32'(ts_beat.syn), 32'd0);
		check_value("ts_beat.head after reset", 32'(ts_beat.head), 32'd0);

		// first frame runs on the reset length
		sym_on = 1'b1;
		count_first_frame(first_strobes);
		if (timeout_count == 0) begin
			check_value("strobes to first frame_start", first_strobes, 32'd9990);
		end

		for (int i = 0; i < row_count; i++) begin
			apply_row(table_rows[i]);
		end

		check_ts_stream(4);

		$display("closing report: %0d check errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("sim passed");
		end
		else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
